// ==== hw/loader_pkg.sv ====
//==================================================
// Shared types and constants for the media loader
// Memory addresses are 25 bits wide and byte wide
// File kinds follow the host download index codes
//==================================================
`default_nettype none

package loader_pkg;

	// ==================================================
	// Address map
	// ==================================================
	localparam int ADDR_W = 25;

	localparam logic [ADDR_W-1:0] CRT_BASE = 25'h0100000;
	localparam logic [ADDR_W-1:0] TAP_BASE = 25'h0200000;
	localparam logic [ADDR_W-1:0] REU_BASE = 25'h1000000;

	// ==================================================
	// Enumerations
	// ==================================================
	typedef enum logic [2:0] {
		LOAD_NONE,
		LOAD_PRG,
		LOAD_CRT,
		LOAD_TAP,
		LOAD_REU
	} load_kind_e;

	typedef enum logic [1:0] {
		CRT_FILE_HDR,
		CRT_CHIP_HDR,
		CRT_CHIP_DATA
	} crt_state_e;

	// ==================================================
	// Structures
	// ==================================================
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_write_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_hdr_t;

	typedef struct packed {
		logic [7:0]  bank_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
	} cart_bank_t;

	// Download index to file kind
	function automatic load_kind_e kind_of(input logic [7:0] index);
		case (index)
			8'h01:        return LOAD_PRG;
			8'h41, 8'h05: return LOAD_CRT;
			8'hC1:        return LOAD_TAP;
			8'h81:        return LOAD_REU;
			default:      return LOAD_NONE;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== hw/load_decoder.sv ====
//==================================================
// Turns the download byte stream into write requests
// The request is combinational on ioctl_wr_i, so the
// host must respect ioctl_wait_o before the next byte
// CRT chip data lands on BANK_ALIGN_BITS boundaries
//==================================================
`timescale 1ns/100ps
`default_nettype none

module load_decoder #(
	parameter int BANK_ALIGN_BITS = 13
) (
	input  wire                            clk_sys,
	input  wire                            RESET,
	input  wire                            ioctl_download_i,
	input  wire [7:0]                      ioctl_index_i,
	input  wire                            ioctl_wr_i,
	input  wire [loader_pkg::ADDR_W-1:0]   ioctl_addr_i,
	input  wire [7:0]                      ioctl_data_i,
	output logic                           dec_req_o,
	output loader_pkg::mem_write_t         dec_wr_o,
	output logic [15:0]                    prg_end_o,
	output loader_pkg::cart_hdr_t          cart_hdr_o,
	output loader_pkg::cart_bank_t         cart_bank_o,
	output logic                           cart_bank_wr_o,
	output logic                           cart_attached_o
);

	localparam int AW = loader_pkg::ADDR_W;

	// File offsets of interest
	localparam logic [AW-1:0] OFS_START    = AW'(8'h00);
	localparam logic [AW-1:0] OFS_PRG_HI   = AW'(8'h01);
	localparam logic [AW-1:0] OFS_PRG_DATA = AW'(8'h02);
	localparam logic [AW-1:0] OFS_ID_HI    = AW'(8'h16);
	localparam logic [AW-1:0] OFS_ID_LO    = AW'(8'h17);
	localparam logic [AW-1:0] OFS_EXROM    = AW'(8'h18);
	localparam logic [AW-1:0] OFS_GAME     = AW'(8'h19);
	localparam logic [AW-1:0] OFS_CHIPS    = AW'(8'h40);

	loader_pkg::load_kind_e kind;
	loader_pkg::crt_state_e crt_state;
	logic [AW-1:0]          load_addr;
	logic [3:0]             hdr_cnt;
	logic [31:0]            blk_len;
	logic                   download_d;
	logic                   in_chips;
	logic                   hdr_start;
	logic                   want_write;

	assign kind     = loader_pkg::kind_of(ioctl_index_i);
	assign in_chips = ioctl_addr_i >= OFS_CHIPS;

	// First byte of a chip packet header
	assign hdr_start = (crt_state == loader_pkg::CRT_FILE_HDR) ||
		(crt_state == loader_pkg::CRT_CHIP_DATA && blk_len == 32'd0);

	// ==================================================
	// Write request path
	// ==================================================
	always_comb begin
		case (kind)
			loader_pkg::LOAD_PRG: want_write = ioctl_addr_i >= OFS_PRG_DATA;
			loader_pkg::LOAD_CRT: want_write = in_chips && !hdr_start &&
				crt_state == loader_pkg::CRT_CHIP_DATA;
			loader_pkg::LOAD_TAP: want_write = 1'b1;
			loader_pkg::LOAD_REU: want_write = 1'b1;
			default:              want_write = 1'b0;
		endcase
	end

	assign dec_req_o = ioctl_wr_i && want_write;

	always_comb begin
		dec_wr_o.data = ioctl_data_i;
		case (kind)
			loader_pkg::LOAD_TAP: dec_wr_o.addr = loader_pkg::TAP_BASE + ioctl_addr_i;
			loader_pkg::LOAD_REU: dec_wr_o.addr = loader_pkg::REU_BASE + ioctl_addr_i;
			default:              dec_wr_o.addr = load_addr;
		endcase
	end

	// ==================================================
	// CRT parse state and status flags
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			crt_state       <= loader_pkg::CRT_FILE_HDR;
			hdr_cnt         <= 4'd0;
			download_d      <= 1'b0;
			cart_bank_wr_o  <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			download_d     <= ioctl_download_i;
			cart_bank_wr_o <= 1'b0;

			// Attached once a CRT download ends, dropped when a new one starts
			if (kind == loader_pkg::LOAD_CRT && download_d != ioctl_download_i)
				cart_attached_o <= download_d;

			if (ioctl_wr_i && kind == loader_pkg::LOAD_CRT) begin
				if (ioctl_addr_i == OFS_START) begin
					crt_state <= loader_pkg::CRT_FILE_HDR;
					hdr_cnt   <= 4'd0;
				end else if (in_chips) begin
					if (hdr_start) begin
						crt_state <= loader_pkg::CRT_CHIP_HDR;
						hdr_cnt   <= 4'd1;
					end else if (crt_state == loader_pkg::CRT_CHIP_HDR) begin
						hdr_cnt <= hdr_cnt + 4'd1;
						if (hdr_cnt == 4'd15) begin
							crt_state      <= loader_pkg::CRT_CHIP_DATA;
							cart_bank_wr_o <= 1'b1;
						end
					end
				end
			end
		end
	end

	// ==================================================
	// Load address, end pointer and header fields
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i && kind == loader_pkg::LOAD_PRG) begin
			if (ioctl_addr_i == OFS_START) begin
				load_addr       <= AW'(ioctl_data_i);
				prg_end_o[7:0]  <= ioctl_data_i;
			end else if (ioctl_addr_i == OFS_PRG_HI) begin
				load_addr[15:8] <= ioctl_data_i;
				prg_end_o[15:8] <= ioctl_data_i;
			end else begin
				load_addr <= load_addr + 1'b1;
				prg_end_o <= prg_end_o + 16'd1;
			end
		end

		if (ioctl_wr_i && kind == loader_pkg::LOAD_CRT) begin
			if (ioctl_addr_i == OFS_START)
				load_addr <= loader_pkg::CRT_BASE;
			if (ioctl_addr_i == OFS_ID_HI)
				cart_hdr_o.id[15:8] <= ioctl_data_i;
			if (ioctl_addr_i == OFS_ID_LO)
				cart_hdr_o.id[7:0] <= ioctl_data_i;
			if (ioctl_addr_i == OFS_EXROM)
				cart_hdr_o.exrom <= ioctl_data_i;
			if (ioctl_addr_i == OFS_GAME)
				cart_hdr_o.game <= ioctl_data_i;

			if (in_chips) begin
				if (hdr_start) begin
					// Round up to the next bank boundary
					if (load_addr[BANK_ALIGN_BITS-1:0] != '0) begin
						load_addr[AW-1:BANK_ALIGN_BITS] <=
							load_addr[AW-1:BANK_ALIGN_BITS] + 1'b1;
						load_addr[BANK_ALIGN_BITS-1:0] <= '0;
					end
				end else if (crt_state == loader_pkg::CRT_CHIP_HDR) begin
					case (hdr_cnt)
						4'd4:  blk_len[31:24] <= ioctl_data_i;
						4'd5:  blk_len[23:16] <= ioctl_data_i;
						4'd6:  blk_len[15:8]  <= ioctl_data_i;
						4'd7:  blk_len[7:0]   <= ioctl_data_i;
						// Packet length includes its own 16-byte header
						4'd8:  blk_len        <= blk_len - 32'd16;
						4'd9:  cart_bank_o.bank_type       <= ioctl_data_i;
						4'd10: cart_bank_o.bank_num[15:8]  <= ioctl_data_i;
						4'd11: cart_bank_o.bank_num[7:0]   <= ioctl_data_i;
						4'd12: cart_bank_o.load_addr[15:8] <= ioctl_data_i;
						4'd13: cart_bank_o.load_addr[7:0]  <= ioctl_data_i;
						4'd14: cart_bank_o.size[15:8]      <= ioctl_data_i;
						4'd15: cart_bank_o.size[7:0]       <= ioctl_data_i;
						default: ;
					endcase
				end else begin
					blk_len   <= blk_len - 32'd1;
					load_addr <= load_addr + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/prg_pointer_injector.sv ====
//==================================================
// Writes the BASIC pointers after a PRG download,
// as the LOAD command would leave them
// Walks page zero one address per cycle and only
// waits on wr_busy_i at the twelve pointer bytes
//==================================================
`timescale 1ns/100ps
`default_nettype none

module prg_pointer_injector (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire                     ioctl_download_i,
	input  wire                     is_prg_i,
	input  wire [15:0]              prg_end_i,
	input  wire                     wr_busy_i,
	output logic                    inj_req_o,
	output loader_pkg::mem_write_t  inj_wr_o,
	output logic                    inj_done_o
);

	localparam int AW = loader_pkg::ADDR_W;

	logic       download_d;
	logic       active;
	logic [7:0] page_addr;
	logic       hit;
	logic [7:0] value;
	logic       start;
	logic       step;

	// Pointer bytes in page zero
	always_comb begin
		hit = 1'b1;
		case (page_addr)
			// Start of BASIC text
			8'h2B: value = 8'h01;
			8'h2C: value = 8'h08;
			8'hAC, 8'hAD: value = 8'h00;
			// VAR, ARY, STR and load end all point past the program
			8'h2D, 8'h2F, 8'h31, 8'hAE: value = prg_end_i[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: value = prg_end_i[15:8];
			default: begin
				hit   = 1'b0;
				value = 8'h00;
			end
		endcase
	end

	assign start = download_d && !ioctl_download_i && is_prg_i;
	assign step  = active && (!hit || !wr_busy_i);

	assign inj_req_o     = active && hit && !wr_busy_i;
	assign inj_wr_o.addr = AW'(page_addr);
	assign inj_wr_o.data = value;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			download_d <= 1'b0;
			active     <= 1'b0;
			page_addr  <= 8'h00;
			inj_done_o <= 1'b0;
		end else begin
			download_d <= ioctl_download_i;
			inj_done_o <= 1'b0;

			if (start) begin
				active    <= 1'b1;
				page_addr <= 8'h00;
			end else if (step) begin
				page_addr <= page_addr + 8'd1;
				if (page_addr == 8'hFF) begin
					active     <= 1'b0;
					inj_done_o <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_write_sequencer.sv ====
//==================================================
// Holds one byte write and issues it in a memory slot
// A request is only taken while wr_busy_o is low
// mem_ce_o pulses once, after io_cycle_i falls
//==================================================
`timescale 1ns/100ps
`default_nettype none

module mem_write_sequencer (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire                     req_i,
	input  loader_pkg::mem_write_t  wr_i,
	input  wire                     io_cycle_i,
	output logic                    wr_busy_o,
	output logic                    mem_ce_o,
	output loader_pkg::mem_write_t  mem_wr_o
);

	logic                   io_cycle_d;
	logic                   slot_end;
	logic                   fire;
	loader_pkg::mem_write_t wr_q;

	// End of the loader slot
	assign slot_end = io_cycle_d && !io_cycle_i;
	assign fire     = wr_busy_o && slot_end;

	// ==================================================
	// Pending flag and write strobe
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			io_cycle_d <= 1'b0;
			wr_busy_o  <= 1'b0;
			mem_ce_o   <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			mem_ce_o   <= fire;
			if (fire)
				wr_busy_o <= 1'b0;
			else if (req_i)
				wr_busy_o <= 1'b1;
		end
	end

	// Held write stays valid through the strobe cycle
	always_ff @(posedge clk_sys) begin
		if (req_i && !wr_busy_o)
			wr_q <= wr_i;
	end

	assign mem_wr_o = wr_q;

endmodule

`default_nettype wire

// ==== hw/media_loader_top.sv ====
//==================================================
// Media loading engine for PRG, CRT, TAP and REU
// Every memory access is a byte write
// ioctl_wait_o must stall the host while high
//==================================================
`timescale 1ns/100ps
`default_nettype none

module media_loader_top #(
	parameter int BANK_ALIGN_BITS = 13
) (
	input  wire                            clk_sys,
	input  wire                            RESET,
	input  wire                            ioctl_download_i,
	input  wire [7:0]                      ioctl_index_i,
	input  wire                            ioctl_wr_i,
	input  wire [loader_pkg::ADDR_W-1:0]   ioctl_addr_i,
	input  wire [7:0]                      ioctl_data_i,
	input  wire                            io_cycle_i,
	output logic                           ioctl_wait_o,
	output logic                           mem_ce_o,
	output loader_pkg::mem_write_t         mem_wr_o,
	output loader_pkg::cart_hdr_t          cart_hdr_o,
	output loader_pkg::cart_bank_t         cart_bank_o,
	output logic                           cart_bank_wr_o,
	output logic                           cart_attached_o,
	output logic                           inj_done_o
);

	logic                   dec_req;
	loader_pkg::mem_write_t dec_wr;
	logic                   inj_req;
	loader_pkg::mem_write_t inj_wr;
	logic                   seq_req;
	loader_pkg::mem_write_t seq_wr;
	logic                   wr_busy;
	logic [15:0]            prg_end;
	logic                   is_prg;

	assign is_prg = loader_pkg::kind_of(ioctl_index_i) == loader_pkg::LOAD_PRG;

	// The two sources never request together
	assign seq_req = dec_req || inj_req;
	assign seq_wr  = inj_req ? inj_wr : dec_wr;

	assign ioctl_wait_o = wr_busy;

	load_decoder #(
		.BANK_ALIGN_BITS (BANK_ALIGN_BITS)
	) u_decoder (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.dec_req_o        (dec_req),
		.dec_wr_o         (dec_wr),
		.prg_end_o        (prg_end),
		.cart_hdr_o       (cart_hdr_o),
		.cart_bank_o      (cart_bank_o),
		.cart_bank_wr_o   (cart_bank_wr_o),
		.cart_attached_o  (cart_attached_o)
	);

	prg_pointer_injector u_injector (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.is_prg_i         (is_prg),
		.prg_end_i        (prg_end),
		.wr_busy_i        (wr_busy),
		.inj_req_o        (inj_req),
		.inj_wr_o         (inj_wr),
		.inj_done_o       (inj_done_o)
	);

	mem_write_sequencer u_sequencer (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.req_i      (seq_req),
		.wr_i       (seq_wr),
		.io_cycle_i (io_cycle_i),
		.wr_busy_o  (wr_busy),
		.mem_ce_o   (mem_ce_o),
		.mem_wr_o   (mem_wr_o)
	);

endmodule

`default_nettype wire

// ==== verification/media_loader_assertions.sv ====
//==================================================
// Protocol checks bound to media_loader_top
// Each failure raises $error and sets a sticky flag
// that the testbench watches through any_fail
//==================================================
`timescale 1ns/100ps
`default_nettype none

module media_loader_assertions (
	input wire clk_sys,
	input wire RESET,
	input wire ioctl_wr_i,
	input wire ioctl_wait_o,
	input wire io_cycle_i,
	input wire mem_ce_o,
	input wire cart_bank_wr_o,
	input wire cart_attached_o,
	input wire inj_done_o
);

	logic ce_twice_fail = 1'b0;
	logic ce_slot_fail  = 1'b0;
	logic wr_wait_fail  = 1'b0;
	logic bank_wr_fail  = 1'b0;
	logic reset_fail    = 1'b0;
	logic any_fail;

	assign any_fail = ce_twice_fail | ce_slot_fail | wr_wait_fail | bank_wr_fail | reset_fail;

	// ==================================================
	// Memory write strobe
	// ==================================================
	ce_single: assert property (@(posedge clk_sys) disable iff (RESET)
		mem_ce_o |=> !mem_ce_o)
		else begin
			ce_twice_fail = 1'b1;
			$error("mem_ce_o high in two consecutive cycles");
		end

	// Write only right after the loader slot ends
	ce_after_slot: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(mem_ce_o) |-> ($past(io_cycle_i, 2) && !$past(io_cycle_i)))
		else begin
			ce_slot_fail = 1'b1;
			$error("mem_ce_o rose without a falling edge of io_cycle_i");
		end

	// ==================================================
	// Host and cartridge handshakes
	// ==================================================
	no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wr_i |-> !ioctl_wait_o)
		else begin
			wr_wait_fail = 1'b1;
			$error("ioctl_wr_i strobed while ioctl_wait_o was high");
		end

	bank_wr_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cart_bank_wr_o |=> !cart_bank_wr_o)
		else begin
			bank_wr_fail = 1'b1;
			$error("cart_bank_wr_o longer than one cycle");
		end

	outputs_after_reset: assert property (@(posedge clk_sys)
		RESET |=> (!ioctl_wait_o && !mem_ce_o && !cart_bank_wr_o &&
			!cart_attached_o && !inj_done_o))
		else begin
			reset_fail = 1'b1;
			$error("Control output high in the cycle after reset");
		end

endmodule

`default_nettype wire

// ==== verification/tb_media_loader.sv ====
//==================================================
// Testbench for media_loader_top
// Host bytes honor ioctl_wait_o
// Memory slot is 2 cycles on and 6 off
// Expected writes are queued before each byte
//==================================================
`timescale 1ns/100ps
`default_nettype none

module tb_media_loader;

	localparam int AW         = loader_pkg::ADDR_W;
	localparam int BANK_BITS  = 13;
	localparam int WAIT_LIMIT = 4000;

	logic                   clk_sys = 1'b0;
	logic                   RESET;
	logic                   ioctl_download_i;
	logic [7:0]             ioctl_index_i;
	logic                   ioctl_wr_i;
	logic [AW-1:0]          ioctl_addr_i;
	logic [7:0]             ioctl_data_i;
	logic                   io_cycle_i = 1'b0;
	logic                   ioctl_wait_o;
	logic                   mem_ce_o;
	loader_pkg::mem_write_t mem_wr_o;
	loader_pkg::cart_hdr_t  cart_hdr_o;
	loader_pkg::cart_bank_t cart_bank_o;
	logic                   cart_bank_wr_o;
	logic                   cart_attached_o;
	logic                   inj_done_o;

	loader_pkg::mem_write_t exp_q[$];
	loader_pkg::cart_bank_t bank_exp[$];
	loader_pkg::mem_write_t exp_head;
	loader_pkg::cart_bank_t bank_head;
	logic [2:0]             slot_cnt = 3'd0;
	int                     bank_seen = 0;
	int                     done_seen = 0;
	string                  test_name = "reset";

	media_loader_top #(
		.BANK_ALIGN_BITS (BANK_BITS)
	) dut (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.io_cycle_i       (io_cycle_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.mem_ce_o         (mem_ce_o),
		.mem_wr_o         (mem_wr_o),
		.cart_hdr_o       (cart_hdr_o),
		.cart_bank_o      (cart_bank_o),
		.cart_bank_wr_o   (cart_bank_wr_o),
		.cart_attached_o  (cart_attached_o),
		.inj_done_o       (inj_done_o)
	);

	bind media_loader_top media_loader_assertions u_protocol_checks (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.ioctl_wr_i      (ioctl_wr_i),
		.ioctl_wait_o    (ioctl_wait_o),
		.io_cycle_i      (io_cycle_i),
		.mem_ce_o        (mem_ce_o),
		.cart_bank_wr_o  (cart_bank_wr_o),
		.cart_attached_o (cart_attached_o),
		.inj_done_o      (inj_done_o)
	);

	initial begin
		forever #2 clk_sys = ~clk_sys;
	end

	// Free running memory slot of 2 cycles in 8
	always @(negedge clk_sys) begin
		slot_cnt   <= slot_cnt + 3'd1;
		io_cycle_i <= (slot_cnt < 3'd2);
	end

	// ==================================================
	// Reporting
	// ==================================================
	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic report_mismatch(input string test, input logic [63:0] exp,
		input logic [63:0] act);
		$display("[FAIL] %s expected %h actual %h", test, exp, act);
		abort_run();
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out in %s while waiting for %s", test_name, what);
		abort_run();
	endtask

	// ==================================================
	// Scoreboard on memory writes and chip descriptors
	// ==================================================
	always @(posedge clk_sys) begin
		if (!RESET && mem_ce_o) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected memory write at %h in %s", mem_wr_o.addr, test_name);
				abort_run();
			end else begin
				exp_head = exp_q.pop_front();
				assert (mem_wr_o == exp_head)
					else report_mismatch(test_name, 64'(exp_head), 64'(mem_wr_o));
			end
		end
		if (!RESET && cart_bank_wr_o) begin
			if (bank_exp.size() == 0) begin
				$display("Unexpected chip descriptor pulse in %s", test_name);
				abort_run();
			end else begin
				bank_head = bank_exp.pop_front();
				assert (cart_bank_o == bank_head)
					else report_mismatch(test_name, 64'(bank_head), 64'(cart_bank_o));
			end
			bank_seen <= bank_seen + 1;
		end
		if (!RESET && inj_done_o)
			done_seen <= done_seen + 1;
		assert (!dut.u_protocol_checks.any_fail)
			else begin
				$display("A bound protocol assertion failed in %s", test_name);
				abort_run();
			end
	end

	// ==================================================
	// Waits with their own timeouts
	// ==================================================
	task automatic wait_not_busy();
		int cycles;
		cycles = 0;
		while (ioctl_wait_o) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout("ioctl_wait_o to fall");
		end
	endtask

	task automatic wait_bank_count(input int target);
		int cycles;
		cycles = 0;
		while (bank_seen < target) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout("cart_bank_wr_o");
		end
	endtask

	task automatic wait_inj_done(input int target);
		int cycles;
		cycles = 0;
		while (done_seen < target) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout("inj_done_o");
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout("the queued memory writes");
		end
	endtask

	// ==================================================
	// Host side
	// ==================================================
	task automatic expect_write(input logic [AW-1:0] addr, input logic [7:0] data);
		loader_pkg::mem_write_t w;
		w.addr = addr;
		w.data = data;
		exp_q.push_back(w);
	endtask

	// One strobe followed by one idle cycle
	task automatic send_byte(input logic [AW-1:0] addr, input logic [7:0] data);
		wait_not_busy();
		ioctl_addr_i = addr;
		ioctl_data_i = data;
		ioctl_wr_i   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr_i = 1'b0;
		@(negedge clk_sys);
	endtask

	function automatic logic [AW-1:0] align_up(input logic [AW-1:0] addr, input int bits);
		logic [AW-1:0] mask;
		mask = (AW'(1) << bits) - AW'(1);
		return (addr + mask) & ~mask;
	endfunction

	// CRT file header with the id, EXROM and GAME fields
	task automatic send_crt_header(input loader_pkg::cart_hdr_t hdr);
		logic [7:0] b;
		for (int ofs = 0; ofs < 64; ofs++) begin
			case (ofs)
				8'h16:   b = hdr.id[15:8];
				8'h17:   b = hdr.id[7:0];
				8'h18:   b = hdr.exrom;
				8'h19:   b = hdr.game;
				// Filler differs per offset so a misplaced field shows
				default: b = 8'(ofs) ^ 8'h5A;
			endcase
			send_byte(AW'(ofs), b);
		end
	endtask

	// CHIP packet of 16 header bytes and count data bytes
	task automatic send_chip(input logic [AW-1:0] ofs, input logic [AW-1:0] dest,
		input logic [7:0] chip_type, input logic [15:0] bank, input logic [15:0] load,
		input int count, input int bank_target);
		logic [7:0]             hdr [16];
		logic [31:0]            pkt_len;
		logic [7:0]             data;
		loader_pkg::cart_bank_t desc;
		pkt_len = 32'(count) + 32'd16;
		hdr[0]  = 8'h43;
		hdr[1]  = 8'h48;
		hdr[2]  = 8'h49;
		hdr[3]  = 8'h50;
		hdr[4]  = pkt_len[31:24];
		hdr[5]  = pkt_len[23:16];
		hdr[6]  = pkt_len[15:8];
		hdr[7]  = pkt_len[7:0];
		hdr[8]  = 8'h00;
		hdr[9]  = chip_type;
		hdr[10] = bank[15:8];
		hdr[11] = bank[7:0];
		hdr[12] = load[15:8];
		hdr[13] = load[7:0];
		hdr[14] = 8'(count >> 8);
		hdr[15] = 8'(count);
		desc.bank_type = chip_type;
		desc.bank_num  = bank;
		desc.load_addr = load;
		desc.size      = 16'(count);
		bank_exp.push_back(desc);
		for (int i = 0; i < 16; i++)
			send_byte(ofs + AW'(i), hdr[i]);
		wait_bank_count(bank_target);
		for (int i = 0; i < count; i++) begin
			data = 8'($urandom);
			expect_write(dest + AW'(i), data);
			send_byte(ofs + AW'(16 + i), data);
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		logic [7:0]            data;
		logic [15:0]           end_ptr;
		logic [AW-1:0]         dest;
		loader_pkg::cart_hdr_t hdr_exp;

		void'($urandom(32'hbb2a));
		RESET            = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = 8'h00;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = 8'h00;
		repeat (5) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		assert (!ioctl_wait_o && !mem_ce_o && !cart_bank_wr_o && !cart_attached_o && !inj_done_o)
			else report_mismatch("reset", 64'd0, 64'({ioctl_wait_o, mem_ce_o,
				cart_bank_wr_o, cart_attached_o, inj_done_o}));

		// PRG loaded at 0801 with ten payload bytes
		test_name        = "prg_payload";
		ioctl_index_i    = 8'h01;
		ioctl_download_i = 1'b1;
		@(negedge clk_sys);
		send_byte(AW'(0), 8'h01);
		send_byte(AW'(1), 8'h08);
		for (int i = 0; i < 10; i++) begin
			data = 8'($urandom);
			expect_write(AW'(16'h0801 + 16'(i)), data);
			send_byte(AW'(2 + i), data);
		end

		// BASIC pointers after the download ends
		test_name = "pointer_inject";
		end_ptr   = 16'h0801 + 16'd10;
		expect_write(AW'(8'h2B), 8'h01);
		expect_write(AW'(8'h2C), 8'h08);
		expect_write(AW'(8'h2D), end_ptr[7:0]);
		expect_write(AW'(8'h2E), end_ptr[15:8]);
		expect_write(AW'(8'h2F), end_ptr[7:0]);
		expect_write(AW'(8'h30), end_ptr[15:8]);
		expect_write(AW'(8'h31), end_ptr[7:0]);
		expect_write(AW'(8'h32), end_ptr[15:8]);
		expect_write(AW'(8'hAC), 8'h00);
		expect_write(AW'(8'hAD), 8'h00);
		expect_write(AW'(8'hAE), end_ptr[7:0]);
		expect_write(AW'(8'hAF), end_ptr[15:8]);
		ioctl_download_i = 1'b0;
		wait_inj_done(1);
		wait_drain();

		// CRT with two 16-byte chips
		test_name        = "crt_parse";
		hdr_exp.id       = 16'h0013;
		hdr_exp.exrom    = 8'h00;
		hdr_exp.game     = 8'h01;
		ioctl_index_i    = 8'h41;
		ioctl_download_i = 1'b1;
		@(negedge clk_sys);
		send_crt_header(hdr_exp);
		dest = loader_pkg::CRT_BASE;
		send_chip(AW'(8'h40), dest, 8'h00, 16'h0000, 16'h8000, 16, 1);
		dest = align_up(dest + AW'(16), BANK_BITS);
		send_chip(AW'(8'h60), dest, 8'h02, 16'h0001, 16'hA000, 16, 2);
		wait_drain();
		ioctl_download_i = 1'b0;
		@(negedge clk_sys);
		assert (cart_hdr_o == hdr_exp)
			else report_mismatch(test_name, 64'(hdr_exp), 64'(cart_hdr_o));
		assert (cart_attached_o)
			else report_mismatch(test_name, 64'd1, 64'(cart_attached_o));

		// Tape image at its fixed base
		test_name        = "tap_copy";
		ioctl_index_i    = 8'hC1;
		ioctl_download_i = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < 6; i++) begin
			data = 8'($urandom);
			expect_write(loader_pkg::TAP_BASE + AW'(i), data);
			send_byte(AW'(i), data);
		end
		wait_drain();
		ioctl_download_i = 1'b0;
		@(negedge clk_sys);

		// REU image at its fixed base
		test_name        = "reu_copy";
		ioctl_index_i    = 8'h81;
		ioctl_download_i = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < 6; i++) begin
			data = 8'($urandom);
			expect_write(loader_pkg::REU_BASE + AW'(i), data);
			send_byte(AW'(i), data);
		end
		wait_drain();
		ioctl_download_i = 1'b0;
		repeat (4) @(negedge clk_sys);

		if (exp_q.size() != 0 || bank_exp.size() != 0) begin
			$display("Expected writes or chip descriptors were never seen");
			abort_run();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/loader_pkg.sv
hw/load_decoder.sv
hw/prg_pointer_injector.sv
hw/mem_write_sequencer.sv
hw/media_loader_top.sv
verification/media_loader_assertions.sv
verification/tb_media_loader.sv

// ==== Makefile ====
# Verilator simulation of the media loader testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_media_loader
FILELIST  ?= sources.f

.PHONY: sim clean

# Pass or fail is taken from the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
